// File: include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and register file geometry
`define CPU_DATA_W       32
`define CPU_REG_ADDR_W   5
`define CPU_REG_NUM      32
`define CPU_INST_W       32

// Primary opcodes, instruction bits 31:26
`define OPC_SPECIAL      6'b000000
`define OPC_ADDI         6'b001000
`define OPC_ADDIU        6'b001001
`define OPC_SLTI         6'b001010
`define OPC_SLTIU        6'b001011
`define OPC_ANDI         6'b001100
`define OPC_ORI          6'b001101
`define OPC_XORI         6'b001110
`define OPC_LUI          6'b001111

// SPECIAL function codes, instruction bits 5:0
`define FN_SLL           6'b000000
`define FN_SRL           6'b000010
`define FN_SRA           6'b000011
`define FN_SLLV          6'b000100
`define FN_SRLV          6'b000110
`define FN_SRAV          6'b000111
`define FN_ADD           6'b100000
`define FN_ADDU          6'b100001
`define FN_SUB           6'b100010
`define FN_SUBU          6'b100011
`define FN_AND           6'b100100
`define FN_OR            6'b100101
`define FN_XOR           6'b100110
`define FN_NOR           6'b100111
`define FN_SLT           6'b101010
`define FN_SLTU          6'b101011

`endif

// File: hw/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0]     data_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

    // Wrapping add and subtract cover both the signed and unsigned forms
    typedef enum logic [3:0] {
        alu_nop  = 4'd0,
        alu_or   = 4'd1,
        alu_and  = 4'd2,
        alu_xor  = 4'd3,
        alu_nor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_add  = 4'd8,
        alu_sub  = 4'd9,
        alu_slt  = 4'd10,
        alu_sltu = 4'd11
    } alu_op_e;

    typedef struct packed {
        logic      rd_en1;
        logic      rd_en2;
        reg_addr_t rd_addr1;
        reg_addr_t rd_addr2;
        logic      wr_en;
        reg_addr_t wr_addr;
        alu_op_e   alu_op;
        data_t     imm;      // Replaces the operand of a port that is not read
    } decode_t;

    typedef struct packed {
        logic      wr_en;
        reg_addr_t wr_addr;
        alu_op_e   alu_op;
        data_t     op1;      // Shift amount in bits 4:0 for shifts
        data_t     op2;
    } id_ex_t;

    typedef struct packed {
        logic      wr_en;
        reg_addr_t wr_addr;
        data_t     wr_data;
    } wb_t;

endpackage

`default_nettype wire

// File: hw/inst_decoder.sv
`default_nettype none

`include "cpu_cfg.svh"

module inst_decoder
    import cpu_pkg::*;
(
    input  wire logic [`CPU_INST_W-1:0] inst,
    input  wire logic                   inst_valid,
    output decode_t                     dec
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    logic        known;
    logic        wr_req;

    // OP 31:26, RS 25:21, RT 20:16, RD 15:11, SA 10:6, FN 5:0, IMM 15:0
    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign shamt  = inst[10:6];
    assign funct  = inst[5:0];
    assign imm16  = inst[15:0];

    always_comb begin
        dec          = '0;
        dec.rd_addr1 = rs;
        dec.rd_addr2 = rt;
        dec.wr_addr  = rd;
        dec.alu_op   = alu_nop;
        known        = 1'b1;
        case (opcode)
            `OPC_SPECIAL: begin
                dec.rd_en1 = 1'b1;
                dec.rd_en2 = 1'b1;
                case (funct)
                    `FN_OR:   dec.alu_op = alu_or;
                    `FN_AND:  dec.alu_op = alu_and;
                    `FN_XOR:  dec.alu_op = alu_xor;
                    `FN_NOR:  dec.alu_op = alu_nor;
                    `FN_SLLV: dec.alu_op = alu_sll; // Amount comes from rs on port 1
                    `FN_SRLV: dec.alu_op = alu_srl;
                    `FN_SRAV: dec.alu_op = alu_sra;
                    `FN_ADD,
                    `FN_ADDU: dec.alu_op = alu_add;
                    `FN_SUB,
                    `FN_SUBU: dec.alu_op = alu_sub;
                    `FN_SLT:  dec.alu_op = alu_slt;
                    `FN_SLTU: dec.alu_op = alu_sltu;
                    `FN_SLL,
                    `FN_SRL,
                    `FN_SRA: begin
                        // Fixed amount rides in imm on port 1
                        dec.rd_en1 = 1'b0;
                        dec.imm    = {{(`CPU_DATA_W-5){1'b0}}, shamt};
                        case (funct)
                            `FN_SLL: dec.alu_op = alu_sll;
                            `FN_SRL: dec.alu_op = alu_srl;
                            default: dec.alu_op = alu_sra;
                        endcase
                    end
                    default: begin
                        dec.rd_en1 = 1'b0;
                        dec.rd_en2 = 1'b0;
                        known      = 1'b0; // MULT, MFHI, SYNC and friends
                    end
                endcase
            end
            `OPC_ORI, `OPC_ANDI, `OPC_XORI: begin
                dec.rd_en1  = 1'b1;
                dec.wr_addr = rt;
                dec.imm     = {{(`CPU_DATA_W-16){1'b0}}, imm16};
                case (opcode)
                    `OPC_ORI:  dec.alu_op = alu_or;
                    `OPC_ANDI: dec.alu_op = alu_and;
                    default:   dec.alu_op = alu_xor;
                endcase
            end
            `OPC_LUI: begin
                // Both ports take imm so the OR returns it unchanged, whatever rs holds
                dec.wr_addr = rt;
                dec.alu_op  = alu_or;
                dec.imm     = {imm16, {(`CPU_DATA_W-16){1'b0}}};
            end
            `OPC_SLTI, `OPC_SLTIU, `OPC_ADDI, `OPC_ADDIU: begin
                dec.rd_en1  = 1'b1;
                dec.wr_addr = rt;
                dec.imm     = {{(`CPU_DATA_W-16){imm16[15]}}, imm16};
                case (opcode)
                    `OPC_SLTI:  dec.alu_op = alu_slt;
                    `OPC_SLTIU: dec.alu_op = alu_sltu; // Sign-extended, then compared unsigned
                    default:    dec.alu_op = alu_add;
                endcase
            end
            default: known = 1'b0;
        endcase

        // Register 0 is only ever protected here
        wr_req     = inst_valid && known;
        dec.wr_en  = wr_req && (dec.wr_addr != '0);
    end

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`default_nettype none

module id_stage
    import cpu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire decode_t dec,
    output reg_addr_t    rf_addr1,
    output reg_addr_t    rf_addr2,
    input  wire data_t   rf_data1,
    input  wire data_t   rf_data2,
    input  wire wb_t     ex_fwd,
    input  wire wb_t     wb,
    output id_ex_t       id_ex
);

    id_ex_t id_ex_nxt;

    // The youngest producer wins, so the execute result is checked before writeback
    function automatic data_t pick_operand(
        input logic      rd_en,
        input reg_addr_t addr,
        input data_t     rf_data,
        input data_t     imm,
        input wb_t       newer,
        input wb_t       older
    );
        data_t value;
        if (!rd_en) begin
            value = imm;
        end else if (newer.wr_en && newer.wr_addr == addr) begin
            value = newer.wr_data;
        end else if (older.wr_en && older.wr_addr == addr) begin
            value = older.wr_data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign rf_addr1 = dec.rd_addr1;
    assign rf_addr2 = dec.rd_addr2;

    always_comb begin
        id_ex_nxt.wr_en   = dec.wr_en;
        id_ex_nxt.wr_addr = dec.wr_addr;
        id_ex_nxt.alu_op  = dec.alu_op;
        id_ex_nxt.op1     = pick_operand(dec.rd_en1, dec.rd_addr1, rf_data1, dec.imm,
                                         ex_fwd, wb);
        id_ex_nxt.op2     = pick_operand(dec.rd_en2, dec.rd_addr2, rf_data2, dec.imm,
                                         ex_fwd, wb);
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_nxt;
        if (!rst_n) begin
            id_ex.wr_en <= 1'b0; // Operands may hold anything after reset
        end
    end

endmodule

`default_nettype wire

// File: hw/ex_stage.sv
`default_nettype none

`include "cpu_cfg.svh"

module ex_stage
    import cpu_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire id_ex_t id_ex,
    output wb_t         ex_fwd,
    output wb_t         wb
);

    localparam int sh_w = $clog2(`CPU_DATA_W);

    logic [sh_w-1:0] sa;
    data_t           result;
    logic            lt_signed;
    logic            lt_unsigned;

    assign sa          = id_ex.op1[sh_w-1:0];
    assign lt_signed   = $signed(id_ex.op1) < $signed(id_ex.op2);
    assign lt_unsigned = id_ex.op1 < id_ex.op2;

    always_comb begin
        case (id_ex.alu_op)
            alu_or:   result = id_ex.op1 | id_ex.op2;
            alu_and:  result = id_ex.op1 & id_ex.op2;
            alu_xor:  result = id_ex.op1 ^ id_ex.op2;
            alu_nor:  result = ~(id_ex.op1 | id_ex.op2);
            alu_sll:  result = id_ex.op2 << sa;
            alu_srl:  result = id_ex.op2 >> sa;
            alu_sra:  result = $signed(id_ex.op2) >>> sa;
            alu_add:  result = id_ex.op1 + id_ex.op2; // No overflow trap
            alu_sub:  result = id_ex.op1 - id_ex.op2;
            alu_slt:  result = {{(`CPU_DATA_W-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`CPU_DATA_W-1){1'b0}}, lt_unsigned};
            default:  result = '0;
        endcase
    end

    // Seen by decode in the same cycle
    assign ex_fwd.wr_en   = id_ex.wr_en;
    assign ex_fwd.wr_addr = id_ex.wr_addr;
    assign ex_fwd.wr_data = result;

    always_ff @(posedge clk) begin
        wb <= ex_fwd;
        if (!rst_n) begin
            wb.wr_en <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`default_nettype none

`include "cpu_cfg.svh"

module reg_file
    import cpu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire reg_addr_t addr1,
    input  wire reg_addr_t addr2,
    output data_t          data1,
    output data_t          data2,
    input  wire wb_t       wr
);

    data_t regs [`CPU_REG_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wr_en) begin
            regs[wr.wr_addr] <= wr.wr_data;
        end
    end

    // Same-cycle write data reaches decode through the writeback forward
    assign data1 = regs[addr1];
    assign data2 = regs[addr2];

endmodule

`default_nettype wire

// File: hw/mips_int_core.sv
`default_nettype none

`include "cpu_cfg.svh"

module mips_int_core
    import cpu_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   inst_valid,
    input  wire logic [`CPU_INST_W-1:0] inst,
    output wb_t                         wb
);

    decode_t   dec;
    reg_addr_t rf_addr1;
    reg_addr_t rf_addr2;
    data_t     rf_data1;
    data_t     rf_data2;
    id_ex_t    id_ex;
    wb_t       ex_fwd;

    inst_decoder i_inst_decoder (
        .inst       (inst),
        .inst_valid (inst_valid),
        .dec        (dec)
    );

    id_stage i_id_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec      (dec),
        .rf_addr1 (rf_addr1),
        .rf_addr2 (rf_addr2),
        .rf_data1 (rf_data1),
        .rf_data2 (rf_data2),
        .ex_fwd   (ex_fwd),
        .wb       (wb),       // Second forwarding source
        .id_ex    (id_ex)
    );

    ex_stage i_ex_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .ex_fwd (ex_fwd),
        .wb     (wb)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .addr1 (rf_addr1),
        .addr2 (rf_addr2),
        .data1 (rf_data1),
        .data2 (rf_data2),
        .wr    (wb)
    );

endmodule

`default_nettype wire

// File: test/tb_mips_int_core.sv
`default_nettype none

`include "cpu_cfg.svh"

module tb_mips_int_core
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period  = 100;
    localparam int total_steps = 80;    // Every driven cycle after reset, drain included

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    wb_t         wb;

    logic [31:0] model [32];            // Architectural register state in program order
    wb_t         exp_q [$];
    wb_t         exp_wb;
    int          n_pushed;
    int          n_checked;
    logic [31:0] lcg_state = 32'hc1ce;

    mips_int_core i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(clk_period * (total_steps + 20));
        $display("Watchdog expired before the tests finished");
        $display("TB FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // One call per clock, so the queue stays aligned with the pipeline
    task automatic drive_cycle(input logic valid, input logic [31:0] word, input wb_t e);
        @(posedge clk);
        #1;
        inst_valid = valid;
        inst       = word;
        exp_q.push_back(e);
        n_pushed++;
    endtask

    task automatic commit(input logic [31:0] word, input logic wr, input logic [4:0] addr,
                          input logic [31:0] data);
        wb_t e;
        e = '0;
        if (wr && addr != 5'd0) begin
            model[addr] = data;
            e.wr_en     = 1'b1;
            e.wr_addr   = addr;
            e.wr_data   = data;
        end
        drive_cycle(1'b1, word, e);
    endtask

    task automatic rtype_op(input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] rs,
                            input logic [4:0] rt, input logic [4:0] sa);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        wr;
        a  = model[rs];
        b  = model[rt];
        r  = '0;
        wr = 1'b1;
        case (fn)
            `FN_OR:   r = a | b;
            `FN_AND:  r = a & b;
            `FN_XOR:  r = a ^ b;
            `FN_NOR:  r = ~(a | b);
            `FN_SLL:  r = b << sa;
            `FN_SRL:  r = b >> sa;
            `FN_SRA:  r = $signed(b) >>> sa;
            `FN_SLLV: r = b << a[4:0];
            `FN_SRLV: r = b >> a[4:0];
            `FN_SRAV: r = $signed(b) >>> a[4:0];
            `FN_ADD,
            `FN_ADDU: r = a + b;
            `FN_SUB,
            `FN_SUBU: r = a - b;
            `FN_SLT:  r = {31'b0, $signed(a) < $signed(b)};
            `FN_SLTU: r = {31'b0, a < b};
            default:  wr = 1'b0; // Dropped functions leave the registers alone
        endcase
        commit({`OPC_SPECIAL, rs, rt, rd, sa, fn}, wr, rd, r);
    endtask

    task automatic itype_op(input logic [5:0] opc, input logic [4:0] rt, input logic [4:0] rs,
                            input logic [15:0] imm);
        logic [31:0] a;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] r;
        logic        wr;
        a  = model[rs];
        se = {{16{imm[15]}}, imm};
        ze = {16'b0, imm};
        r  = '0;
        wr = 1'b1;
        case (opc)
            `OPC_ORI:   r = a | ze;
            `OPC_ANDI:  r = a & ze;
            `OPC_XORI:  r = a ^ ze;
            `OPC_LUI:   r = {imm, 16'h0000};
            `OPC_ADDI,
            `OPC_ADDIU: r = a + se;
            `OPC_SLTI:  r = {31'b0, $signed(a) < $signed(se)};
            `OPC_SLTIU: r = {31'b0, a < se};
            default:    wr = 1'b0;
        endcase
        commit({opc, rs, rt, imm}, wr, rt, r);
    endtask

    task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
        itype_op(`OPC_LUI, r, 5'd0, v[31:16]);
        itype_op(`OPC_ORI, r, r, v[15:0]);
    endtask

    always @(negedge clk) begin
        if (exp_q.size() > 2) begin
            exp_wb = exp_q.pop_front();
            compare_value("wb.wr_en", wb.wr_en, exp_wb.wr_en);
            if (exp_wb.wr_en) begin
                compare_value("wb.wr_addr", wb.wr_addr, exp_wb.wr_addr);
                compare_value("wb.wr_data", wb.wr_data, exp_wb.wr_data);
            end
            n_checked++;
        end
    end

    task automatic reset_sequence();
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            if (i == 0) begin
                // A writing instruction held during reset must never reach wb
                inst_valid = 1'b1;
                inst       = {`OPC_ORI, 5'd0, 5'd1, 16'hffff};
            end
            if (i == 2) begin
                rst_n      = 1'b1;
                inst_valid = 1'b0;
                inst       = '0;
            end
            @(negedge clk);
            compare_value("wb.wr_en", wb.wr_en, 1'b0);
        end
        drive_cycle(1'b0, '0, '0);
        @(negedge clk);
        compare_value("wb.wr_en", wb.wr_en, 1'b0);
    endtask

    task automatic logic_ops();
        logic [31:0] v;
        for (int r = 1; r <= 6; r++) begin
            load_reg(r[4:0], next_rand());
        end
        v = next_rand();
        itype_op(`OPC_ANDI, 5'd7, 5'd1, v[15:0]);
        itype_op(`OPC_XORI, 5'd8, 5'd2, v[31:16]);
        rtype_op(`FN_OR, 5'd9, 5'd3, 5'd4, 5'd0);
        rtype_op(`FN_AND, 5'd10, 5'd5, 5'd6, 5'd0);
        rtype_op(`FN_XOR, 5'd11, 5'd1, 5'd2, 5'd0);
        rtype_op(`FN_NOR, 5'd12, 5'd3, 5'd6, 5'd0);
    endtask

    task automatic shift_ops();
        logic [31:0] v;
        for (int r = 13; r <= 15; r++) begin
            load_reg(r[4:0], next_rand() | 32'h8000_0000);
        end
        rtype_op(`FN_SLL, 5'd16, 5'd0, 5'd13, 5'd7);
        rtype_op(`FN_SRL, 5'd17, 5'd0, 5'd14, 5'd13);
        rtype_op(`FN_SRA, 5'd18, 5'd0, 5'd15, 5'd19);
        // Upper bits of the amount registers must be ignored
        for (int r = 19; r <= 21; r++) begin
            v = next_rand();
            itype_op(`OPC_ORI, r[4:0], 5'd0, v[31:16]);
        end
        rtype_op(`FN_SLLV, 5'd22, 5'd19, 5'd13, 5'd0);
        rtype_op(`FN_SRLV, 5'd23, 5'd20, 5'd14, 5'd0);
        rtype_op(`FN_SRAV, 5'd24, 5'd21, 5'd15, 5'd0);
    endtask

    task automatic arith_ops();
        load_reg(5'd25, 32'h7fff_fff0);
        load_reg(5'd26, 32'h8000_0010);
        load_reg(5'd27, next_rand());
        rtype_op(`FN_ADD, 5'd28, 5'd25, 5'd25, 5'd0);   // Positive overflow wraps
        rtype_op(`FN_ADDU, 5'd29, 5'd26, 5'd26, 5'd0);
        rtype_op(`FN_SUB, 5'd30, 5'd26, 5'd25, 5'd0);
        rtype_op(`FN_SUBU, 5'd31, 5'd25, 5'd26, 5'd0);
        itype_op(`OPC_ADDI, 5'd28, 5'd25, 16'h7fff);
        itype_op(`OPC_ADDIU, 5'd29, 5'd27, 16'h8000);
        rtype_op(`FN_SLT, 5'd30, 5'd26, 5'd25, 5'd0);
        rtype_op(`FN_SLTU, 5'd31, 5'd26, 5'd25, 5'd0);
        itype_op(`OPC_SLTI, 5'd28, 5'd26, 16'h0001);
        itype_op(`OPC_SLTIU, 5'd29, 5'd25, 16'hffff);
        itype_op(`OPC_SLTIU, 5'd30, 5'd26, 16'h0010);
    endtask

    task automatic forwarding_chains();
        logic [31:0] v;
        v = next_rand();
        itype_op(`OPC_ADDIU, 5'd1, 5'd0, v[15:0]);
        rtype_op(`FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0);
        rtype_op(`FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0);
        rtype_op(`FN_SUBU, 5'd4, 5'd1, 5'd3, 5'd0);     // r1 three back, r3 one back
        rtype_op(`FN_XOR, 5'd5, 5'd2, 5'd4, 5'd0);
        // Both forwarding sources hold r6 here
        itype_op(`OPC_ORI, 5'd6, 5'd0, v[31:16]);
        itype_op(`OPC_ORI, 5'd6, 5'd0, ~v[15:0]);
        rtype_op(`FN_ADDU, 5'd7, 5'd6, 5'd6, 5'd0);
        rtype_op(`FN_SUBU, 5'd8, 5'd6, 5'd7, 5'd0);
        for (int i = 0; i < 8; i++) begin
            rtype_op(`FN_ADDU, 5'd11, 5'd11, 5'd1, 5'd0);
        end
    endtask

    task automatic suppressed_writes();
        rtype_op(`FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0);
        itype_op(`OPC_ORI, 5'd0, 5'd3, 16'hbeef);
        rtype_op(6'b011000, 5'd0, 5'd1, 5'd2, 5'd0);      // MULT
        rtype_op(6'b010000, 5'd5, 5'd0, 5'd0, 5'd0);      // MFHI
        rtype_op(6'b001111, 5'd0, 5'd0, 5'd0, 5'd0);      // SYNC
        drive_cycle(1'b0, {`OPC_SPECIAL, 5'd1, 5'd2, 5'd12, 5'd0, `FN_ADDU}, '0);
        drive_cycle(1'b0, {`OPC_ORI, 5'd0, 5'd13, 16'h1234}, '0);
        rtype_op(`FN_ADDU, 5'd13, 5'd0, 5'd0, 5'd0);
        rtype_op(`FN_OR, 5'd14, 5'd0, 5'd5, 5'd0);
        itype_op(`OPC_ADDIU, 5'd15, 5'd0, 16'h1234);
    endtask

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        n_pushed   = 0;
        n_checked  = 0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end

        reset_sequence();
        logic_ops();
        shift_ops();
        arith_ops();
        forwarding_chains();
        suppressed_writes();

        // Two idle cycles push the last instruction out to wb
        drive_cycle(1'b0, '0, '0);
        drive_cycle(1'b0, '0, '0);
        @(posedge clk);
        compare_value("checked count", n_checked, n_pushed - 2);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: mips_int_core.f
+incdir+include
hw/cpu_pkg.sv
hw/inst_decoder.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/reg_file.sv
hw/mips_int_core.sv
test/tb_mips_int_core.sv
